/* src/tcdm_cfg.svh */
// TCDM log interconnect configuration
// core and bank counts, widths, bank depth and the test-and-set bit

`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

`define TCDM_N_CORES    4
`define TCDM_N_BANKS    4    // power of two
`define TCDM_ADDR_W     16   // byte address
`define TCDM_DATA_W     32
`define TCDM_BANK_WORDS 64
`define TCDM_TS_BIT     15   // set means atomic test-and-set read

// derived widths
`define TCDM_BE_W       (`TCDM_DATA_W / 8)
`define TCDM_BYTE_OFF_W ($clog2(`TCDM_BE_W))
`define TCDM_BANK_IDX_W ($clog2(`TCDM_N_BANKS))
`define TCDM_ROW_W      ($clog2(`TCDM_BANK_WORDS))
`define TCDM_ROW_LSB    (`TCDM_BYTE_OFF_W + `TCDM_BANK_IDX_W)
`define TCDM_ID_W       ($clog2(`TCDM_N_CORES) + 1)  // all-ones id is reserved

`endif

/* src/tcdm_pkg.sv */
// TCDM log interconnect types
// width typedefs, core and bank side request/response structs,
// control word and the test-and-set FSM states

`default_nettype none

`include "tcdm_cfg.svh"

package tcdm_pkg;

  typedef logic [`TCDM_ADDR_W-1:0] addr_t;
  typedef logic [`TCDM_DATA_W-1:0] data_t;
  typedef logic [`TCDM_BE_W-1:0]   be_t;
  typedef logic [`TCDM_ID_W-1:0]   core_id_t;  // one extra bit for the internal write
  typedef logic [`TCDM_ROW_W-1:0]  row_t;

  // core side, req/gnt handshake
  typedef struct packed {
    logic  req;
    logic  wen;   // high means read
    addr_t add;
    data_t data;
    be_t   be;
  } tcdm_req_t;

  typedef struct packed {
    logic  r_valid;
    data_t r_data;
  } tcdm_resp_t;

  // bank side
  typedef struct packed {
    logic     req;
    logic     wen;
    row_t     row;
    data_t    data;
    be_t      be;
    core_id_t id;
  } bank_req_t;

  typedef struct packed {
    logic     r_valid;
    data_t    r_data;
    core_id_t r_id;
  } bank_resp_t;

  typedef struct packed {
    logic arb_policy;  // 0 round-robin, 1 fixed priority
  } tcdm_ctrl_t;

  typedef enum logic {
    TS_IDLE,
    TS_WRITE
  } ts_state_e;

endpackage

`default_nettype wire

/* src/tcdm_bank_arbiter.sv */
// TCDM bank arbiter
// picks one core per cycle for a single bank, round-robin with a rotating
// pointer or fixed priority with core 0 highest, and builds the bank request

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_cfg.svh"

module tcdm_bank_arbiter (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  tcdm_pkg::tcdm_ctrl_t                    ctrl_i,
  input  tcdm_pkg::tcdm_req_t [`TCDM_N_CORES-1:0] req_i,    // already filtered to this bank
  input  logic                                    ready_i,  // low while the bank is locked
  output logic [`TCDM_N_CORES-1:0]                gnt_o,
  output tcdm_pkg::bank_req_t                     bank_req_o,
  output logic                                    ts_o
);

  localparam int unsigned NC    = `TCDM_N_CORES;
  localparam int unsigned PTR_W = (NC > 1) ? $clog2(NC) : 1;

  logic [PTR_W-1:0] ptr_q;     // round-robin priority pointer
  logic [PTR_W-1:0] ptr_next;
  logic [PTR_W-1:0] winner;
  logic             found;
  logic             grant;

  // search starts at the pointer, or at core 0 for fixed priority
  always_comb begin
    int idx;
    found  = 1'b0;
    winner = '0;
    for (int i = 0; i < NC; i++) begin
      idx = ctrl_i.arb_policy ? i : (i + int'(ptr_q)) % NC;
      if (!found && req_i[idx].req) begin
        found  = 1'b1;
        winner = PTR_W'(idx);
      end
    end
  end

  assign grant = found & ready_i;

  always_comb begin
    gnt_o         = '0;
    gnt_o[winner] = grant;
  end

  // forward the winner, address turned into a row inside the bank
  always_comb begin
    bank_req_o.req  = grant;
    bank_req_o.wen  = req_i[winner].wen;
    bank_req_o.row  = req_i[winner].add[`TCDM_ROW_LSB +: `TCDM_ROW_W];
    bank_req_o.data = req_i[winner].data;
    bank_req_o.be   = req_i[winner].be;
    bank_req_o.id   = tcdm_pkg::core_id_t'(winner);
  end

  assign ts_o = req_i[winner].add[`TCDM_TS_BIT];  // only looked at with req

  // one past the winner, wrapping at the core count
  assign ptr_next = (winner == PTR_W'(NC - 1)) ? '0 : winner + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (grant) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

`default_nettype wire

/* src/tcdm_test_set.sv */
// TCDM test-and-set sequencer
// turns a test-and-set read into the read itself followed by an
// all-ones write to the same row, locking the bank for that cycle

`timescale 1ns/10ps
`default_nettype none

module tcdm_test_set (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::bank_req_t bank_req_i,
  input  logic                ts_i,
  output logic                ready_o,
  output tcdm_pkg::bank_req_t bank_req_o
);

  tcdm_pkg::ts_state_e state_q;
  tcdm_pkg::ts_state_e state_d;
  tcdm_pkg::row_t      row_q;    // row of the pending atomic write
  logic                ts_accept;

  assign ts_accept = bank_req_i.req & bank_req_i.wen & ts_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      tcdm_pkg::TS_IDLE: begin
        if (ts_accept) begin
          state_d = tcdm_pkg::TS_WRITE;
        end
      end
      tcdm_pkg::TS_WRITE: state_d = tcdm_pkg::TS_IDLE;  // single locked cycle
      default:            state_d = tcdm_pkg::TS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tcdm_pkg::TS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ts_accept) begin
      row_q <= bank_req_i.row;
    end
  end

  assign ready_o = (state_q == tcdm_pkg::TS_IDLE);

  // the internal write uses the reserved id, so the bank stays silent
  always_comb begin
    if (state_q == tcdm_pkg::TS_WRITE) begin
      bank_req_o.req  = 1'b1;
      bank_req_o.wen  = 1'b0;
      bank_req_o.row  = row_q;
      bank_req_o.data = '1;
      bank_req_o.be   = '1;
      bank_req_o.id   = '1;
    end else begin
      bank_req_o = bank_req_i;
    end
  end

endmodule

`default_nettype wire

/* src/tcdm_bank.sv */
// TCDM memory bank, behavioral
// single-port word array with byte-enable writes; every access gets a
// registered response one cycle later, tagged with the requester id

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_cfg.svh"

module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  tcdm_pkg::bank_req_t  bank_req_i,
  output tcdm_pkg::bank_resp_t bank_resp_o
);

  localparam int unsigned BE_W = `TCDM_BE_W;

  tcdm_pkg::data_t    mem_q [`TCDM_BANK_WORDS];
  tcdm_pkg::data_t    r_data_q;
  tcdm_pkg::core_id_t r_id_q;
  logic               r_valid_q;
  logic               internal_wr;  // sequencer write gets no response

  assign internal_wr = (bank_req_i.id == '1);

  // word array with byte-enable writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < `TCDM_BANK_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (bank_req_i.req && !bank_req_i.wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (bank_req_i.be[b]) begin
          mem_q[bank_req_i.row][8*b +: 8] <= bank_req_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bank_req_i.req && bank_req_i.wen) begin
      r_data_q <= mem_q[bank_req_i.row];  // old word, before any write
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      r_id_q    <= '0;
    end else begin
      r_valid_q <= bank_req_i.req & ~internal_wr;
      if (bank_req_i.req) begin
        r_id_q <= bank_req_i.id;
      end
    end
  end

  assign bank_resp_o.r_valid = r_valid_q;
  assign bank_resp_o.r_data  = r_data_q;  // stale for writes
  assign bank_resp_o.r_id    = r_id_q;

endmodule

`default_nettype wire

/* src/tcdm_resp_router.sv */
// TCDM response router
// steers each bank response to the core named by its id, combinational

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_cfg.svh"

module tcdm_resp_router (
  input  tcdm_pkg::bank_resp_t [`TCDM_N_BANKS-1:0] bank_resp_i,
  output tcdm_pkg::tcdm_resp_t [`TCDM_N_CORES-1:0] cores_resp_o
);

  localparam int unsigned NC = `TCDM_N_CORES;
  localparam int unsigned NB = `TCDM_N_BANKS;

  // at most one bank matches a given core in any cycle
  always_comb begin
    for (int c = 0; c < NC; c++) begin
      cores_resp_o[c].r_valid = 1'b0;
      cores_resp_o[c].r_data  = '0;
      for (int b = 0; b < NB; b++) begin
        if (bank_resp_i[b].r_valid &&
            bank_resp_i[b].r_id == tcdm_pkg::core_id_t'(c)) begin
          cores_resp_o[c].r_valid = 1'b1;
          cores_resp_o[c].r_data  = bank_resp_i[b].r_data;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/tcdm_log_interconnect.sv */
// TCDM logarithmic interconnect, top level
// word-interleaved cores-to-banks crossbar: per bank an arbiter, a
// test-and-set sequencer and a memory bank, plus one response router

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_cfg.svh"

module tcdm_log_interconnect (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  tcdm_pkg::tcdm_ctrl_t                     ctrl_i,
  input  tcdm_pkg::tcdm_req_t  [`TCDM_N_CORES-1:0] cores_req_i,
  output logic                 [`TCDM_N_CORES-1:0] cores_gnt_o,
  output tcdm_pkg::tcdm_resp_t [`TCDM_N_CORES-1:0] cores_resp_o
);

  localparam int unsigned NC = `TCDM_N_CORES;
  localparam int unsigned NB = `TCDM_N_BANKS;

  logic [NC-1:0][`TCDM_BANK_IDX_W-1:0] core_bank;   // target bank per core
  tcdm_pkg::tcdm_req_t [NB-1:0][NC-1:0] bank_reqs;  // requests masked per bank
  logic [NB-1:0][NC-1:0]                bank_gnt;
  tcdm_pkg::bank_req_t  [NB-1:0]        arb_req;
  tcdm_pkg::bank_req_t  [NB-1:0]        mem_req;
  tcdm_pkg::bank_resp_t [NB-1:0]        mem_resp;
  logic [NB-1:0]                        arb_ts;
  logic [NB-1:0]                        bank_ready;

  // bank index sits right above the byte offset
  always_comb begin
    for (int c = 0; c < NC; c++) begin
      core_bank[c] = cores_req_i[c].add[`TCDM_BYTE_OFF_W +: `TCDM_BANK_IDX_W];
    end
  end

  always_comb begin
    for (int b = 0; b < NB; b++) begin
      for (int c = 0; c < NC; c++) begin
        bank_reqs[b][c]     = cores_req_i[c];
        bank_reqs[b][c].req = cores_req_i[c].req & (int'(core_bank[c]) == b);
      end
    end
  end

  // a core targets a single bank, so at most one grant per core
  always_comb begin
    cores_gnt_o = '0;
    for (int b = 0; b < NB; b++) begin
      cores_gnt_o = cores_gnt_o | bank_gnt[b];
    end
  end

  for (genvar b = 0; b < NB; b++) begin : g_bank
    tcdm_bank_arbiter u_arb (
      .clk_i      ( clk_i         ),
      .rst_ni     ( rst_ni        ),
      .ctrl_i     ( ctrl_i        ),
      .req_i      ( bank_reqs[b]  ),
      .ready_i    ( bank_ready[b] ),
      .gnt_o      ( bank_gnt[b]   ),
      .bank_req_o ( arb_req[b]    ),
      .ts_o       ( arb_ts[b]     )
    );

    tcdm_test_set u_ts (
      .clk_i      ( clk_i         ),
      .rst_ni     ( rst_ni        ),
      .bank_req_i ( arb_req[b]    ),
      .ts_i       ( arb_ts[b]     ),
      .ready_o    ( bank_ready[b] ),
      .bank_req_o ( mem_req[b]    )
    );

    tcdm_bank u_bank (
      .clk_i       ( clk_i       ),
      .rst_ni      ( rst_ni      ),
      .bank_req_i  ( mem_req[b]  ),
      .bank_resp_o ( mem_resp[b] )
    );
  end

  tcdm_resp_router u_router (
    .bank_resp_i  ( mem_resp     ),
    .cores_resp_o ( cores_resp_o )
  );

endmodule

`default_nettype wire

/* sim/tcdm_checker.sv */
// TCDM interconnect checker
// watches the core ports, keeps a reference memory and compares
// grants and responses cycle by cycle

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_cfg.svh"

module tcdm_checker (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  tcdm_pkg::tcdm_ctrl_t                     ctrl_i,
  input  tcdm_pkg::tcdm_req_t  [`TCDM_N_CORES-1:0] cores_req_i,
  input  logic                 [`TCDM_N_CORES-1:0] cores_gnt_i,
  input  tcdm_pkg::tcdm_resp_t [`TCDM_N_CORES-1:0] cores_resp_i,
  output int                                       checks_o,
  output int                                       errors_o
);

  localparam int NC     = `TCDM_N_CORES;
  localparam int NB     = `TCDM_N_BANKS;
  localparam int WORD_W = `TCDM_BANK_IDX_W + `TCDM_ROW_W;
  localparam int WORDS  = 2 ** WORD_W;

  tcdm_pkg::data_t model_mem [WORDS];  // whole TCDM, word addressed
  tcdm_pkg::data_t exp_data  [NC];
  logic [NC-1:0]   exp_valid;          // response due this cycle
  logic [NC-1:0]   exp_read;
  logic [NB-1:0]   locked;             // bank busy with the atomic write
  int              rr_wait   [NC];     // grants to others while waiting

  function automatic int bank_of(input tcdm_pkg::addr_t a);
    return int'(a[`TCDM_BYTE_OFF_W +: `TCDM_BANK_IDX_W]);
  endfunction

  function automatic int word_of(input tcdm_pkg::addr_t a);
    return int'(a[`TCDM_BYTE_OFF_W +: WORD_W]);
  endfunction

  task automatic compare(input string test, input tcdm_pkg::data_t exp,
                         input tcdm_pkg::data_t act);
    checks_o++;
    if (act !== exp) begin
      errors_o++;
      $display("** Error %s at %0t: expected %h, actual %h", test, $time, exp, act);
    end
  endtask

  initial begin
    checks_o = 0;
    errors_o = 0;
  end

  always @(posedge clk_i or negedge rst_ni) begin : watch
    logic [NC-1:0] granted;
    logic [NB-1:0] bank_busy;
    logic [NB-1:0] next_locked;
    int            n_req;
    int            n_gnt;
    int            first;
    int            w;
    if (!rst_ni) begin
      for (int i = 0; i < WORDS; i++) begin
        model_mem[i] = '0;  // banks come out of reset cleared
      end
      exp_valid = '0;
      exp_read  = '0;
      locked    = '0;
      for (int c = 0; c < NC; c++) begin
        rr_wait[c] = 0;
      end
    end else begin
      // responses to the grants of the previous cycle
      for (int c = 0; c < NC; c++) begin
        compare($sformatf("r_valid core%0d", c), exp_valid[c], cores_resp_i[c].r_valid);
        if (exp_valid[c] && exp_read[c] && cores_resp_i[c].r_valid) begin
          compare($sformatf("r_data core%0d", c), exp_data[c], cores_resp_i[c].r_data);
        end
        granted[c] = cores_gnt_i[c] & cores_req_i[c].req;
        compare($sformatf("gnt without req core%0d", c), 0,
                cores_gnt_i[c] & ~cores_req_i[c].req);
      end
      // one grant per requested bank, none while it is locked
      for (int b = 0; b < NB; b++) begin
        n_req = 0;
        n_gnt = 0;
        for (int c = 0; c < NC; c++) begin
          if (cores_req_i[c].req && bank_of(cores_req_i[c].add) == b) begin
            n_req++;
            n_gnt += int'(granted[c]);
          end
        end
        bank_busy[b] = (n_gnt > 0);
        if (locked[b]) begin
          compare($sformatf("ts lock bank%0d", b), 0, n_gnt);
        end else if (n_req > 0) begin
          compare($sformatf("grant count bank%0d", b), 1, n_gnt);
        end
      end
      // arbitration policy
      for (int c = 0; c < NC; c++) begin
        if (ctrl_i.arb_policy || !cores_req_i[c].req || granted[c]) begin
          rr_wait[c] = 0;
        end else if (bank_busy[bank_of(cores_req_i[c].add)]) begin
          rr_wait[c]++;
          if (rr_wait[c] == NC) begin
            compare($sformatf("round-robin wait core%0d", c), NC - 1, rr_wait[c]);
          end
        end
        if (ctrl_i.arb_policy && granted[c]) begin
          first = -1;
          for (int j = c - 1; j >= 0; j--) begin  // lowest index ends up in first
            if (cores_req_i[j].req &&
                bank_of(cores_req_i[j].add) == bank_of(cores_req_i[c].add)) begin
              first = j;
            end
          end
          if (first >= 0) begin
            compare("fixed priority winner", first, c);
          end
        end
      end
      // apply this cycle's accesses in grant order
      next_locked = '0;
      for (int c = 0; c < NC; c++) begin
        exp_valid[c] = granted[c];
        exp_read[c]  = cores_req_i[c].wen;
        if (granted[c]) begin
          w = word_of(cores_req_i[c].add);
          if (cores_req_i[c].wen) begin
            exp_data[c] = model_mem[w];
            if (cores_req_i[c].add[`TCDM_TS_BIT]) begin
              model_mem[w] = '1;  // atomic write follows the read
              next_locked[bank_of(cores_req_i[c].add)] = 1'b1;
            end
          end else begin
            for (int k = 0; k < `TCDM_BE_W; k++) begin
              if (cores_req_i[c].be[k]) begin
                model_mem[w][8*k +: 8] = cores_req_i[c].data[8*k +: 8];
              end
            end
          end
        end
      end
      locked = next_locked;
    end
  end

endmodule

`default_nettype wire

/* sim/tb_tcdm_log_interconnect.sv */
// TCDM interconnect testbench
// random traffic from every core, bank contention under both
// arbitration policies and directed test-and-set sequences

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_cfg.svh"

module tb_tcdm_log_interconnect;

  localparam int NC          = `TCDM_N_CORES;
  localparam int NB          = `TCDM_N_BANKS;
  localparam int GNT_TIMEOUT = 200;  // cycles

  logic                            clk;
  logic                            rst_n;
  tcdm_pkg::tcdm_ctrl_t            ctrl;
  tcdm_pkg::tcdm_req_t             core_req [NC];  // one driver process per core
  tcdm_pkg::tcdm_req_t  [NC-1:0]   cores_req;
  logic                 [NC-1:0]   cores_gnt;
  tcdm_pkg::tcdm_resp_t [NC-1:0]   cores_resp;
  int                              n_checks;
  int                              n_errors;
  int                              timeouts;
  int                              seed;
  tcdm_pkg::tcdm_req_t             stim_q [NC][$];
  int                              gap_q  [NC][$];

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always_comb begin
    for (int c = 0; c < NC; c++) begin
      cores_req[c] = core_req[c];
    end
  end

  tcdm_log_interconnect u_tcdm_log_interconnect (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .ctrl_i       ( ctrl       ),
    .cores_req_i  ( cores_req  ),
    .cores_gnt_o  ( cores_gnt  ),
    .cores_resp_o ( cores_resp )
  );

  tcdm_checker u_checker (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .ctrl_i       ( ctrl       ),
    .cores_req_i  ( cores_req  ),
    .cores_gnt_i  ( cores_gnt  ),
    .cores_resp_i ( cores_resp ),
    .checks_o     ( n_checks   ),
    .errors_o     ( n_errors   )
  );

  function automatic int draw(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic tcdm_pkg::tcdm_req_t make_req(input int word, input logic wen,
                                                   input logic ts);
    tcdm_pkg::tcdm_req_t r;
    r      = '0;
    r.req  = 1'b1;
    r.wen  = wen;
    r.add  = tcdm_pkg::addr_t'(word << `TCDM_BYTE_OFF_W);
    r.add[`TCDM_TS_BIT] = ts;
    r.data = $random(seed);
    r.be   = tcdm_pkg::be_t'(draw(2 ** `TCDM_BE_W));
    return r;
  endfunction

  // n requests per core on one bank or on all banks when bank is negative
  task automatic queue_random(input int n, input int span, input int bank, input int max_gap);
    int   word;
    logic wen;
    for (int k = 0; k < n; k++) begin
      for (int c = 0; c < NC; c++) begin
        word = (bank < 0) ? draw(span) : draw(span / NB) * NB + bank;
        wen  = (draw(2) == 1);
        stim_q[c].push_back(make_req(word, wen, wen && draw(6) == 0));
        gap_q[c].push_back(draw(max_gap + 1));
      end
    end
  endtask

  // core 0 writes, test-and-sets and rereads a word while the others read its bank
  task automatic queue_atomic(input int word);
    tcdm_pkg::tcdm_req_t r;
    r    = make_req(word, 1'b0, 1'b0);
    r.be = '1;
    stim_q[0].push_back(r);
    stim_q[0].push_back(make_req(word, 1'b1, 1'b1));
    stim_q[0].push_back(make_req(word, 1'b1, 1'b0));
    for (int c = 0; c < NC; c++) begin
      for (int k = 0; k < 3; k++) begin
        if (c > 0) begin
          stim_q[c].push_back(make_req(word + NB * (k + 1), 1'b1, 1'b0));
        end
        gap_q[c].push_back(0);
      end
    end
  endtask

  task automatic run_core(input int c);
    int   gap;
    int   waited;
    logic granted;
    while (stim_q[c].size() > 0) begin
      gap = gap_q[c].pop_front();
      repeat (gap) @(negedge clk);
      core_req[c] = stim_q[c].pop_front();
      waited  = 0;
      granted = 1'b0;
      while (!granted && waited < GNT_TIMEOUT) begin
        @(posedge clk);
        granted = cores_gnt[c];
        waited++;
      end
      @(negedge clk);
      core_req[c] = '0;
      if (!granted) begin
        timeouts++;
        $display("core %0d got no grant within %0d cycles", c, GNT_TIMEOUT);
        stim_q[c].delete();
        gap_q[c].delete();
      end
    end
  endtask

  task automatic run_all();
    fork
      run_core(0);
      run_core(1);
      run_core(2);
      run_core(3);
    join
  endtask

  initial begin
    seed     = 32'hb9931dde;
    rst_n    = 1'b0;
    ctrl     = '0;
    timeouts = 0;
    for (int c = 0; c < NC; c++) begin
      core_req[c] = '0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);     // idle cycles with nothing granted or answered
    queue_random(60, 16, -1, 3);   // mixed traffic over all banks
    run_all();
    queue_random(20, 16, 1, 0);    // every core on bank 1 under round-robin
    run_all();
    ctrl.arb_policy = 1'b1;
    queue_random(20, 16, 1, 0);
    run_all();
    ctrl.arb_policy = 1'b0;
    queue_atomic(6);
    queue_atomic(9);
    run_all();
    repeat (4) @(negedge clk);     // drain the last responses
    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, timeouts);
    if (n_errors == 0 && timeouts == 0 && n_checks > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/tcdm_pkg.sv
src/tcdm_bank_arbiter.sv
src/tcdm_test_set.sv
src/tcdm_bank.sv
src/tcdm_resp_router.sv
src/tcdm_log_interconnect.sv
sim/tcdm_checker.sv
sim/tb_tcdm_log_interconnect.sv

/* run.sh */
#!/usr/bin/env bash
# build the TCDM interconnect testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal --timing \
  --top-module tb_tcdm_log_interconnect \
  -f sources.f -o tb_tcdm_log_interconnect \
  && ./obj_dir/tb_tcdm_log_interconnect | tee /dev/stderr \
     | grep -q "All tests passed" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
